// ==== Bender.yml ====
package:
  name: coreDatapath

sources:
  - common/isaPkg.sv
  - common/aluPkg.sv
  - verilog/decode/aluDecoder.sv
  - verilog/decode/registerFile.sv
  - verilog/decode/instrDecode.sv
  - verilog/execute/alu.sv
  - verilog/execute/execStage.sv
  - verilog/coreDatapath.sv
  - target: test
    files:
      - test/coreDatapath_assert.sv
      - test/coreDatapathTb.sv

// ==== all.f ====
common/isaPkg.sv
common/aluPkg.sv
verilog/decode/aluDecoder.sv
verilog/decode/registerFile.sv
verilog/decode/instrDecode.sv
verilog/execute/alu.sv
verilog/execute/execStage.sv
verilog/coreDatapath.sv
test/coreDatapath_assert.sv
test/coreDatapathTb.sv

// ==== common/aluPkg.sv ====
`default_nettype none

package aluPkg;

	// operation class chosen by the decoder from the opcode
	typedef enum logic [1:0] {
		aluOpAdd    = 2'b00,
		aluOpBranch = 2'b01,
		aluOpFunct  = 2'b10,
		aluOpUnset  = 2'b11
	} aluOpT;

	typedef enum logic [3:0] {
		aluAdd  = 4'b0000,
		aluSub  = 4'b0001,
		aluAnd  = 4'b0010,
		aluOr   = 4'b0011,
		aluXor  = 4'b0100,
		aluSll  = 4'b0101,
		aluSrl  = 4'b0110,
		aluSra  = 4'b0111,
		aluSlt  = 4'b1000,
		aluSltu = 4'b1001
	} aluCtrlT;

endpackage

`default_nettype wire

// ==== common/isaPkg.sv ====
`default_nettype none

package isaPkg;

	// base opcodes of the RV32I subset handled here
	typedef enum logic [6:0] {
		opR     = 7'b0110011,
		opImm   = 7'b0010011,
		opLoad  = 7'b0000011,
		opStore = 7'b0100011,
		opBranch = 7'b1100011,
		opJal   = 7'b1101111,
		opJalr  = 7'b1100111,
		opLui   = 7'b0110111,
		opAuipc = 7'b0010111
	} opcodeT;

	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3Srl    = 3'b101; // srl and sra share this code
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Bne  = 3'b001;
	localparam logic [2:0] f3Blt  = 3'b100;
	localparam logic [2:0] f3Bge  = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rFmtT;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iFmtT;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sFmtT;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic imm11;
		logic [6:0] opcode;
	} bFmtT;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} uFmtT;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10to1;
		logic imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jFmtT;

	// one instruction word, viewed through each encoding format
	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
		sFmtT sFmt;
		bFmtT bFmt;
		uFmtT uFmt;
		jFmtT jFmt;
	} instrT;

endpackage

`default_nettype wire

// ==== test/coreDatapathTb.sv ====
`default_nettype none

module coreDatapathTb;

	timeunit 1ns;
	timeprecision 100ps;

	import isaPkg::*;

	localparam int NumCycles = 2000; // stimulus cycles
	localparam int MaxCycles = NumCycles + NumCycles / 2;

	logic clk = 1'b0;
	logic arstN;
	logic instrValid;
	isaPkg::instrT instr;
	logic [31:0] pc;
	logic resultValid;
	logic [4:0] rdAddr;
	logic [31:0] rdData;
	logic rdWrite;
	logic memValid;
	logic memWrite;
	logic [31:0] memAddr;
	logic [31:0] storeData;
	logic branchTaken;
	logic [31:0] branchTarget;
	logic illegal;

	logic [31:0] model [32]; // reference register file
	int cycleCount = 0;

	// expected outputs for the next cycle
	logic expValid, expRdWrite, expMemValid, expMemWrite, expTaken, expIllegal;
	logic [4:0] expRdAddr;
	logic [31:0] expRdData, expMemAddr, expStoreData, expTarget;
	logic chkRdAddr, chkRdData, chkTarget;

	coreDatapath #(
		.NumRegs(32)
	) DUT (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.resultValid(resultValid),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.rdWrite(rdWrite),
		.memValid(memValid),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.storeData(storeData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.illegal(illegal)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= MaxCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", MaxCycles);
			$display("*** FAILED ***");
			$fatal(1, "timeout");
		end
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "output mismatch");
		end
	endtask

	// the bound checker counts the assertions that failed
	task automatic checkAssertions();
		if (DUT.uAssert.failedAsserts != 0) begin
			$display("An assertion of the bound checker failed before %0t", $time);
			$display("*** FAILED ***");
			$fatal(1, "assertion failure");
		end
	endtask

	function automatic logic isKnownOpcode(input logic [6:0] op);
		return op inside {opR, opImm, opLoad, opStore, opBranch, opJal, opJalr, opLui, opAuipc};
	endfunction

	// mostly x0..x4 so that results feed later instructions
	function automatic logic [4:0] pickReg();
		if ($urandom_range(3, 0) != 0)
			return 5'($urandom_range(4, 0));
		return 5'($urandom);
	endfunction

	function automatic logic [6:0] pickIllegalOpcode();
		logic [6:0] op;
		op = 7'($urandom);
		while (isKnownOpcode(op))
			op = 7'($urandom);
		return op;
	endfunction

	function automatic logic [31:0] makeInstr();
		logic [31:0] w;
		logic coin;
		w = $urandom;
		coin = $urandom_range(1, 0);
		w[11:7] = pickReg();
		w[19:15] = pickReg();
		if ($urandom_range(99, 0) < 3) begin
			w[6:0] = pickIllegalOpcode();
			return w;
		end
		case ($urandom_range(8, 0))
			0: begin
				w[6:0] = opR;
				w[24:20] = pickReg();
				w[31:25] = (coin && (w[14:12] == f3AddSub || w[14:12] == f3Srl)) ? 7'h20 : 7'h00;
			end
			1: begin
				w[6:0] = opImm;
				if (w[14:12] == f3Sll || w[14:12] == f3Srl)
					w[31:25] = (coin && w[14:12] == f3Srl) ? 7'h20 : 7'h00; // srai or srli
			end
			2: w[6:0] = opLoad;
			3: begin
				w[6:0] = opStore;
				w[24:20] = pickReg();
			end
			4: begin
				w[6:0] = opBranch;
				w[24:20] = pickReg();
				case ($urandom_range(5, 0))
					0: w[14:12] = f3Beq;
					1: w[14:12] = f3Bne;
					2: w[14:12] = f3Blt;
					3: w[14:12] = f3Bge;
					4: w[14:12] = f3Bltu;
					default: w[14:12] = f3Bgeu;
				endcase
			end
			5: w[6:0] = opJal;
			6: begin
				w[6:0] = opJalr;
				w[14:12] = 3'b000;
			end
			7: w[6:0] = opLui;
			default: w[6:0] = opAuipc;
		endcase
		return w;
	endfunction

	// integer operations as the RV32I spec defines them
	function automatic logic [31:0] arithResult(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchCondition(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			f3Beq: return a == b;
			f3Bne: return a != b;
			f3Blt: return $signed(a) < $signed(b);
			f3Bge: return !($signed(a) < $signed(b));
			f3Bltu: return a < b;
			default: return !(a < b);
		endcase
	endfunction

	// expected outputs of one strobe, register update at the same edge
	task automatic predict(input logic valid, input logic [31:0] w, input logic [31:0] pcIn);
		logic [31:0] a, b, res, immI, immS, immB, immU, immJ;
		logic [2:0] f3;
		logic writes;
		a = model[w[19:15]];
		b = model[w[24:20]];
		f3 = w[14:12];
		immI = {{20{w[31]}}, w[31:20]};
		immS = {{20{w[31]}}, w[31:25], w[11:7]};
		immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		immU = {w[31:12], 12'b0};
		immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		res = '0;
		writes = 1'b0;
		{expValid, expRdWrite, expMemValid, expMemWrite, expTaken, expIllegal} = '0;
		{chkRdAddr, chkRdData, chkTarget} = '0;
		expRdAddr = w[11:7];
		expValid = valid;
		if (valid) begin
			chkRdAddr = 1'b1;
			case (w[6:0])
				opR: begin
					res = arithResult(f3, (f3 == 3'b000 || f3 == 3'b101) && w[30], a, b);
					writes = 1'b1;
				end
				opImm: begin
					res = arithResult(f3, f3 == 3'b101 && w[30], a, immI);
					writes = 1'b1;
				end
				opLui, opAuipc: begin
					res = (w[6:0] == opLui) ? immU : pcIn + immU;
					writes = 1'b1;
				end
				opJal, opJalr: begin
					res = pcIn + 32'd4;
					writes = 1'b1;
					expTaken = 1'b1;
					expTarget = (w[6:0] == opJal) ? pcIn + immJ : (a + immI) & ~32'd1;
					chkTarget = 1'b1;
				end
				opBranch: begin
					expTaken = branchCondition(f3, a, b);
					expTarget = pcIn + immB;
					chkTarget = 1'b1;
					expRdAddr = 5'd0; // B-type has no rd
				end
				opLoad: begin
					expMemValid = 1'b1;
					expMemAddr = a + immI;
				end
				opStore: begin
					expMemValid = 1'b1;
					expMemWrite = 1'b1;
					expMemAddr = a + immS;
					expStoreData = b;
					expRdAddr = 5'd0;
				end
				default: begin
					expIllegal = 1'b1;
					chkRdAddr = 1'b0;
				end
			endcase
		end
		chkRdData = writes;
		expRdData = res;
		expRdWrite = writes && w[11:7] != 5'd0;
		if (expRdWrite)
			model[w[11:7]] = res;
	endtask

	task automatic checkOutputs();
		checkValue("resultValid", 32'(expValid), 32'(resultValid));
		checkValue("rdWrite", 32'(expRdWrite), 32'(rdWrite));
		checkValue("memValid", 32'(expMemValid), 32'(memValid));
		checkValue("memWrite", 32'(expMemWrite), 32'(memWrite));
		checkValue("branchTaken", 32'(expTaken), 32'(branchTaken));
		checkValue("illegal", 32'(expIllegal), 32'(illegal));
		if (chkRdAddr)
			checkValue("rdAddr", 32'(expRdAddr), 32'(rdAddr));
		if (chkRdData)
			checkValue("rdData", expRdData, rdData);
		if (expMemValid)
			checkValue("memAddr", expMemAddr, memAddr);
		if (expMemWrite)
			checkValue("storeData", expStoreData, storeData);
		if (chkTarget)
			checkValue("branchTarget", expTarget, branchTarget);
	endtask

	initial begin
		logic [31:0] w;
		logic [31:0] pcNext;
		logic strobe;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		for (int i = 0; i < 32; i++)
			model[i] = '0; // all registers start at zero after reset
		predict(1'b0, 32'd0, 32'd0);
		void'($urandom(51875));
		repeat (5) @(posedge clk);
		#1 arstN = 1'b1;
		for (int n = 0; n < NumCycles; n++) begin
			@(posedge clk);
			#1;
			checkOutputs();
			checkAssertions();
			strobe = $urandom_range(99, 0) < 70;
			w = makeInstr();
			pcNext = $urandom;
			pcNext[1:0] = 2'b00; // word-aligned pc
			predict(strobe, w, pcNext);
			instrValid = strobe;
			instr = w;
			pc = pcNext;
		end
		@(posedge clk);
		#1;
		checkOutputs();
		checkAssertions();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/coreDatapath_assert.sv ====
`default_nettype none

module coreDatapathAssert (
	input wire clk,
	input wire arstN,
	input wire instrValid,
	input wire resultValid,
	input wire rdWrite,
	input wire [4:0] rdAddr,
	input wire branchTaken,
	input wire memValid,
	input wire illegal
);

	timeunit 1ns;
	timeprecision 100ps;

	int failedAsserts = 0; // failed assertions so far

	// one result for every strobe, one cycle later
	resultFollowsStrobe: assert property (@(posedge clk) disable iff (!arstN)
		resultValid == $past(instrValid))
		else begin
			failedAsserts++;
			$error("resultValid does not follow instrValid of the previous cycle");
		end

	noWriteToZero: assert property (@(posedge clk) disable iff (!arstN)
		rdWrite |-> rdAddr != 5'd0)
		else begin
			failedAsserts++;
			$error("rdWrite asserted with rdAddr zero");
		end

	flagsNeedResult: assert property (@(posedge clk) disable iff (!arstN)
		(branchTaken || memValid || illegal) |-> resultValid)
		else begin
			failedAsserts++;
			$error("branchTaken, memValid or illegal high without resultValid");
		end

endmodule

bind coreDatapath coreDatapathAssert uAssert (
	.clk(clk),
	.arstN(arstN),
	.instrValid(instrValid),
	.resultValid(resultValid),
	.rdWrite(rdWrite),
	.rdAddr(rdAddr),
	.branchTaken(branchTaken),
	.memValid(memValid),
	.illegal(illegal)
);

`default_nettype wire

// ==== verilog/coreDatapath.sv ====
`default_nettype none

module coreDatapath #(
	parameter int NumRegs = 32 // 16 for RV32E
) (
	input wire clk,
	input wire arstN,
	input wire instrValid,
	input wire isaPkg::instrT instr,
	input wire [31:0] pc,
	output logic resultValid,
	output logic [4:0] rdAddr,
	output logic [31:0] rdData,
	output logic rdWrite,
	output logic memValid,
	output logic memWrite,
	output logic [31:0] memAddr,
	output logic [31:0] storeData,
	output logic branchTaken,
	output logic [31:0] branchTarget,
	output logic illegal
);

	import isaPkg::*;
	import aluPkg::*;

	opcodeT decOpcode;
	logic [2:0] decFunct3;
	logic [4:0] decRdAddr;
	logic [31:0] decRs1Data;
	logic [31:0] decRs2Data;
	logic [31:0] decImmExt;
	aluCtrlT decAluCtrl;
	logic decIllegal;

	// write-back loop from execute into the register file
	logic wbEn;
	logic [4:0] wbAddr;
	logic [31:0] wbData;

	instrDecode #(
		.NumRegs(NumRegs)
	) uDecode (
		.clk(clk),
		.arstN(arstN),
		.instr(instr),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.opcode(decOpcode),
		.funct3(decFunct3),
		.rdAddr(decRdAddr),
		.rs1Data(decRs1Data),
		.rs2Data(decRs2Data),
		.immExt(decImmExt),
		.aluCtrl(decAluCtrl),
		.illegal(decIllegal)
	);

	execStage uExec (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.pc(pc),
		.opcode(decOpcode),
		.funct3(decFunct3),
		.rdAddr(decRdAddr),
		.rs1Data(decRs1Data),
		.rs2Data(decRs2Data),
		.immExt(decImmExt),
		.aluCtrl(decAluCtrl),
		.illegalIn(decIllegal),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.resultValid(resultValid),
		.rdAddrQ(rdAddr),
		.rdData(rdData),
		.rdWrite(rdWrite),
		.memValid(memValid),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.storeData(storeData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.illegal(illegal)
	);

endmodule

`default_nettype wire

// ==== verilog/decode/aluDecoder.sv ====
`default_nettype none

module aluDecoder (
	input wire aluPkg::aluOpT aluOp,
	input wire [2:0] funct3,
	input wire funct7b5,
	input wire isRType,
	output aluPkg::aluCtrlT aluCtrl
);

	import isaPkg::*;
	import aluPkg::*;

	always_comb begin
		case (aluOp)
			aluOpBranch: begin
				case (funct3)
					f3Beq, f3Bne: aluCtrl = aluSub; // equality through zero flag
					f3Blt, f3Bge: aluCtrl = aluSlt;
					default: aluCtrl = aluSltu;
				endcase
			end
			aluOpFunct: begin
				case (funct3)
					f3AddSub: aluCtrl = (isRType && funct7b5) ? aluSub : aluAdd; // addi has no sub
					f3Sll: aluCtrl = aluSll;
					f3Slt: aluCtrl = aluSlt;
					f3Sltu: aluCtrl = aluSltu;
					f3Xor: aluCtrl = aluXor;
					f3Srl: aluCtrl = funct7b5 ? aluSra : aluSrl;
					f3Or: aluCtrl = aluOr;
					default: aluCtrl = aluAnd;
				endcase
			end
			default: aluCtrl = aluAdd; // aluOpAdd and unset
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/decode/instrDecode.sv ====
`default_nettype none

module instrDecode #(
	parameter int NumRegs = 32
) (
	input wire clk,
	input wire arstN,
	input wire isaPkg::instrT instr,
	input wire wbEn,
	input wire [4:0] wbAddr,
	input wire [31:0] wbData,
	output isaPkg::opcodeT opcode,
	output logic [2:0] funct3,
	output logic [4:0] rdAddr,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data,
	output logic [31:0] immExt,
	output aluPkg::aluCtrlT aluCtrl,
	output logic illegal
);

	import isaPkg::*;
	import aluPkg::*;

	logic [4:0] rs1Addr;
	logic [4:0] rs2Addr;
	aluOpT aluOp;
	logic isShiftImm;
	logic funct7b5;

	assign opcode = opcodeT'(instr.rFmt.opcode); // same bits in every format

	// funct7 only matters for R-type and for the immediate shifts
	assign isShiftImm = (opcode == opImm) &&
		(instr.iFmt.funct3 == f3Sll || instr.iFmt.funct3 == f3Srl);
	assign funct7b5 = (opcode == opR || isShiftImm) ? instr.rFmt.funct7[5] : 1'b0;

	always_comb begin
		rs1Addr = '0;
		rs2Addr = '0;
		rdAddr = '0;
		funct3 = '0;
		immExt = '0;
		aluOp = aluOpUnset;
		illegal = 1'b0;
		case (opcode)
			opR: begin
				rs1Addr = instr.rFmt.rs1;
				rs2Addr = instr.rFmt.rs2;
				rdAddr = instr.rFmt.rd;
				funct3 = instr.rFmt.funct3;
				aluOp = aluOpFunct;
			end
			opImm, opLoad, opJalr: begin
				rs1Addr = instr.iFmt.rs1;
				rdAddr = instr.iFmt.rd;
				immExt = {{20{instr.iFmt.imm[11]}}, instr.iFmt.imm};
				if (opcode == opImm) begin
					funct3 = instr.iFmt.funct3;
					aluOp = aluOpFunct;
				end else begin
					funct3 = (opcode == opLoad) ? instr.iFmt.funct3 : 3'b000;
					aluOp = aluOpAdd; // rs1 + imm
				end
			end
			opStore: begin
				rs1Addr = instr.sFmt.rs1;
				rs2Addr = instr.sFmt.rs2;
				funct3 = instr.sFmt.funct3;
				immExt = {{20{instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
				aluOp = aluOpAdd;
			end
			opBranch: begin
				rs1Addr = instr.bFmt.rs1;
				rs2Addr = instr.bFmt.rs2;
				funct3 = instr.bFmt.funct3;
				immExt = {{19{instr.bFmt.imm12}}, instr.bFmt.imm12, instr.bFmt.imm11,
					instr.bFmt.imm10to5, instr.bFmt.imm4to1, 1'b0};
				aluOp = aluOpBranch;
			end
			opLui, opAuipc: begin
				rdAddr = instr.uFmt.rd;
				immExt = {instr.uFmt.imm, 12'b0};
				aluOp = aluOpAdd; // operand a supplies zero or pc
			end
			opJal: begin
				rdAddr = instr.jFmt.rd;
				immExt = {{11{instr.jFmt.imm20}}, instr.jFmt.imm20, instr.jFmt.imm19to12,
					instr.jFmt.imm11, instr.jFmt.imm10to1, 1'b0};
			end
			default: illegal = 1'b1;
		endcase
	end

	aluDecoder uAluDec (
		.aluOp(aluOp),
		.funct3(funct3),
		.funct7b5(funct7b5),
		.isRType(opcode == opR),
		.aluCtrl(aluCtrl)
	);

	registerFile #(
		.NumRegs(NumRegs)
	) uRegFile (
		.clk(clk),
		.arstN(arstN),
		.rAddr1(rs1Addr),
		.rAddr2(rs2Addr),
		.wEn(wbEn),
		.wAddr(wbAddr),
		.wData(wbData),
		.rData1(rs1Data),
		.rData2(rs2Data)
	);

endmodule

`default_nettype wire

// ==== verilog/decode/registerFile.sv ====
`default_nettype none

module registerFile #(
	parameter int NumRegs = 32
) (
	input wire clk,
	input wire arstN,
	input wire [4:0] rAddr1,
	input wire [4:0] rAddr2,
	input wire wEn,
	input wire [4:0] wAddr,
	input wire [31:0] wData,
	output logic [31:0] rData1,
	output logic [31:0] rData2
);

	logic [31:0] regs [NumRegs];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wEn && wAddr != 5'd0 && wAddr < NumRegs) begin
			regs[wAddr] <= wData;
		end
	end

	// x0 and indices past the bank read as zero
	assign rData1 = (rAddr1 != 5'd0 && rAddr1 < NumRegs) ? regs[rAddr1] : '0;
	assign rData2 = (rAddr2 != 5'd0 && rAddr2 < NumRegs) ? regs[rAddr2] : '0;

endmodule

`default_nettype wire

// ==== verilog/execute/alu.sv ====
`default_nettype none

module alu (
	input wire [31:0] a,
	input wire [31:0] b,
	input wire aluPkg::aluCtrlT ctrl,
	output logic [31:0] y,
	output logic zero
);

	import aluPkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (ctrl)
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			aluXor: y = a ^ b;
			aluSll: y = a << shamt;
			aluSrl: y = a >> shamt;
			aluSra: y = $signed(a) >>> shamt; // keeps the sign bit
			aluSlt: y = {31'b0, $signed(a) < $signed(b)};
			aluSltu: y = {31'b0, a < b};
			default: y = '0;
		endcase
	end

	assign zero = (y == 32'd0); // used by the branch decision

endmodule

`default_nettype wire

// ==== verilog/execute/execStage.sv ====
`default_nettype none

module execStage (
	input wire clk,
	input wire arstN,
	input wire instrValid,
	input wire [31:0] pc,
	input wire isaPkg::opcodeT opcode,
	input wire [2:0] funct3,
	input wire [4:0] rdAddr,
	input wire [31:0] rs1Data,
	input wire [31:0] rs2Data,
	input wire [31:0] immExt,
	input wire aluPkg::aluCtrlT aluCtrl,
	input wire illegalIn,
	output logic wbEn,
	output logic [4:0] wbAddr,
	output logic [31:0] wbData,
	output logic resultValid,
	output logic [4:0] rdAddrQ,
	output logic [31:0] rdData,
	output logic rdWrite,
	output logic memValid,
	output logic memWrite,
	output logic [31:0] memAddr,
	output logic [31:0] storeData,
	output logic branchTaken,
	output logic [31:0] branchTarget,
	output logic illegal
);

	import isaPkg::*;

	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] aluY;
	logic aluZero;
	logic [31:0] result;
	logic [31:0] target;
	logic isJump;
	logic isMem;
	logic writesReg;
	logic taken;

	always_comb begin
		case (opcode)
			opAuipc: opA = pc;
			opLui: opA = '0;
			default: opA = rs1Data;
		endcase
	end

	assign opB = (opcode == opR || opcode == opBranch) ? rs2Data : immExt;

	alu uAlu (
		.a(opA),
		.b(opB),
		.ctrl(aluCtrl),
		.y(aluY),
		.zero(aluZero)
	);

	assign isJump = (opcode == opJal) || (opcode == opJalr);
	assign isMem = (opcode == opLoad) || (opcode == opStore);
	assign result = isJump ? pc + 32'd4 : aluY; // link address for jumps
	assign target = (opcode == opJalr) ? {aluY[31:1], 1'b0} : pc + immExt;

	// slt/sltu leave y at one when the compare holds
	always_comb begin
		taken = 1'b0;
		if (isJump) begin
			taken = 1'b1;
		end else if (opcode == opBranch) begin
			case (funct3)
				f3Beq: taken = aluZero;
				f3Bne: taken = !aluZero;
				f3Blt, f3Bltu: taken = !aluZero;
				f3Bge, f3Bgeu: taken = aluZero;
				default: taken = 1'b0;
			endcase
		end
	end

	assign writesReg = !illegalIn && (opcode inside {opR, opImm, opLui, opAuipc, opJal, opJalr});

	// write-back lands at the same edge as the output register
	assign wbEn = instrValid && writesReg && (rdAddr != 5'd0);
	assign wbAddr = rdAddr;
	assign wbData = result;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resultValid <= 1'b0;
			rdWrite <= 1'b0;
			memValid <= 1'b0;
			memWrite <= 1'b0;
			branchTaken <= 1'b0;
			illegal <= 1'b0;
		end else begin
			resultValid <= instrValid;
			rdWrite <= wbEn;
			memValid <= instrValid && isMem;
			memWrite <= instrValid && (opcode == opStore);
			branchTaken <= instrValid && taken;
			illegal <= instrValid && illegalIn;
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			rdAddrQ <= rdAddr;
			rdData <= result;
			memAddr <= aluY; // rs1 + imm for loads and stores
			storeData <= rs2Data;
			branchTarget <= target;
		end
	end

endmodule

`default_nettype wire
